//--- logic/z80_defines.svh
`ifndef Z80_DEFINES_SVH
`define Z80_DEFINES_SVH

// Memory port widths
`define Z80_ADDR_W 16
`define Z80_DATA_W 8

// LD dd,nn and the (nn) loads are the longest kept instructions
`define Z80_INSN_MAX 3

// Execution starts at the bottom of memory
`define Z80_RESET_PC 16'h0000

`endif

//--- logic/z80_pkg.sv
package z80_pkg;

    // Unprefixed load groups kept by the sequencer
    typedef enum logic [3:0] {
        GRP_NOP,
        GRP_LD_R_R,
        GRP_LD_R_N,
        GRP_LD_R_IND_HL,
        GRP_LD_IND_HL_R,
        GRP_LD_IND_HL_N,
        GRP_LD_A_IND_NN,
        GRP_LD_IND_NN_A,
        GRP_LD_DD_NN,
        GRP_UNKNOWN
    } insn_group_t;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_MEM,
        ST_DONE
    } seq_state_t;

    // Register field encoding as it appears in the opcode
    typedef enum logic [2:0] {
        REG_B      = 3'd0,
        REG_C      = 3'd1,
        REG_D      = 3'd2,
        REG_E      = 3'd3,
        REG_H      = 3'd4,
        REG_L      = 3'd5,
        REG_IND_HL = 3'd6,
        REG_A      = 3'd7
    } reg_sel_t;

    typedef enum logic [1:0] {
        PAIR_BC,
        PAIR_DE,
        PAIR_HL,
        PAIR_SP
    } pair_sel_t;

endpackage

//--- logic/reg_file_if.sv
`include "z80_defines.svh"

interface reg_file_if;
    import z80_pkg::*;

    reg_sel_t rd_sel;
    logic [`Z80_DATA_W-1:0] rd_data;
    logic [`Z80_ADDR_W-1:0] hl;

    // wr_pair selects a 16 bit pair write over a single register write
    logic wr_en;
    logic wr_pair;
    reg_sel_t wr_sel;
    pair_sel_t wr_pair_sel;
    logic [2*`Z80_DATA_W-1:0] wr_data;

    modport seq (
        output rd_sel, wr_en, wr_pair, wr_sel, wr_pair_sel, wr_data,
        input  rd_data, hl
    );

    modport regs (
        input  rd_sel, wr_en, wr_pair, wr_sel, wr_pair_sel, wr_data,
        output rd_data, hl
    );
endinterface

//--- logic/insn_decoder.sv
`include "z80_defines.svh"

module insn_decoder (
    input  logic [`Z80_DATA_W-1:0] opcode,
    output z80_pkg::insn_group_t group,
    output logic [1:0] length
);
    import z80_pkg::*;

    always_comb begin
        group = GRP_UNKNOWN;
        length = 2'd1;

        if (opcode == 8'h00) begin
            group = GRP_NOP;
        end else if (opcode == 8'h76) begin
            // HALT sits in the move row but is not a load
            group = GRP_UNKNOWN;
        end else if (opcode[7:6] == 2'b01) begin
            if (opcode[2:0] == REG_IND_HL) begin
                group = GRP_LD_R_IND_HL;
            end else if (opcode[5:3] == REG_IND_HL) begin
                group = GRP_LD_IND_HL_R;
            end else begin
                group = GRP_LD_R_R;
            end
        end else if (opcode[7:6] == 2'b00 && opcode[2:0] == 3'b110) begin
            length = 2'd2;
            if (opcode[5:3] == REG_IND_HL) begin
                group = GRP_LD_IND_HL_N;
            end else begin
                group = GRP_LD_R_N;
            end
        end else if (opcode[7:6] == 2'b00 && opcode[3:0] == 4'b0001) begin
            group = GRP_LD_DD_NN;
            length = 2'd3;
        end else if (opcode == 8'h32) begin
            group = GRP_LD_IND_NN_A;
            length = 2'd3;
        end else if (opcode == 8'h3a) begin
            group = GRP_LD_A_IND_NN;
            length = 2'd3;
        end
    end

endmodule

//--- logic/register_file.sv
`include "z80_defines.svh"

module register_file (
    input logic clk,
    input logic reset,
    reg_file_if.regs rf
);
    import z80_pkg::*;

    logic [`Z80_DATA_W-1:0] reg_b;
    logic [`Z80_DATA_W-1:0] reg_c;
    logic [`Z80_DATA_W-1:0] reg_d;
    logic [`Z80_DATA_W-1:0] reg_e;
    logic [`Z80_DATA_W-1:0] reg_h;
    logic [`Z80_DATA_W-1:0] reg_l;
    logic [`Z80_DATA_W-1:0] reg_a;
    logic [2*`Z80_DATA_W-1:0] sp;

    assign rf.hl = {reg_h, reg_l};

    always_comb begin
        case (rf.rd_sel)
            REG_B:   rf.rd_data = reg_b;
            REG_C:   rf.rd_data = reg_c;
            REG_D:   rf.rd_data = reg_d;
            REG_E:   rf.rd_data = reg_e;
            REG_H:   rf.rd_data = reg_h;
            REG_L:   rf.rd_data = reg_l;
            REG_A:   rf.rd_data = reg_a;
            default: rf.rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {reg_b, reg_c, reg_d, reg_e, reg_h, reg_l, reg_a} <= '0;
            sp <= '0;
        end else if (rf.wr_en && rf.wr_pair) begin
            // High byte goes to the first register of the pair
            case (rf.wr_pair_sel)
                PAIR_BC: {reg_b, reg_c} <= rf.wr_data;
                PAIR_DE: {reg_d, reg_e} <= rf.wr_data;
                PAIR_HL: {reg_h, reg_l} <= rf.wr_data;
                PAIR_SP: sp <= rf.wr_data;
            endcase
        end else if (rf.wr_en) begin
            case (rf.wr_sel)
                REG_B:   reg_b <= rf.wr_data[`Z80_DATA_W-1:0];
                REG_C:   reg_c <= rf.wr_data[`Z80_DATA_W-1:0];
                REG_D:   reg_d <= rf.wr_data[`Z80_DATA_W-1:0];
                REG_E:   reg_e <= rf.wr_data[`Z80_DATA_W-1:0];
                REG_H:   reg_h <= rf.wr_data[`Z80_DATA_W-1:0];
                REG_L:   reg_l <= rf.wr_data[`Z80_DATA_W-1:0];
                REG_A:   reg_a <= rf.wr_data[`Z80_DATA_W-1:0];
                default: ;
            endcase
        end
    end

endmodule

//--- logic/z80_sequencer.sv
`include "z80_defines.svh"

module z80_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic [`Z80_DATA_W-1:0] mem_data,
    output logic [`Z80_ADDR_W-1:0] addr,
    output logic read_mem,
    output logic write_mem,
    output logic [`Z80_DATA_W-1:0] write_data,
    output logic done,
    output logic [`Z80_DATA_W-1:0] opcode,
    input  z80_pkg::insn_group_t group,
    input  logic [1:0] length,
    reg_file_if.seq rf
);
    import z80_pkg::*;

    localparam int INSN_W = `Z80_INSN_MAX * `Z80_DATA_W;

    seq_state_t state;
    seq_state_t next_state;
    logic [`Z80_ADDR_W-1:0] pc;
    logic [`Z80_ADDR_W-1:0] next_pc;
    logic [`Z80_ADDR_W-1:0] next_addr;
    logic [2*`Z80_DATA_W-1:0] insn;
    logic [2*`Z80_DATA_W-1:0] next_insn;
    logic [INSN_W-1:0] cur_insn;
    logic [1:0] count;
    logic [1:0] next_count;
    logic [1:0] cur_len;
    logic next_read;
    logic next_write;
    logic [`Z80_DATA_W-1:0] next_wdata;
    logic [`Z80_DATA_W-1:0] imm8;
    logic [2*`Z80_DATA_W-1:0] imm16;
    logic finish;

    // Bytes collected so far, with the byte on the bus appended
    always_comb begin
        case (count)
            2'd0:    cur_insn = {16'h0000, mem_data};
            2'd1:    cur_insn = {8'h00, mem_data, insn[7:0]};
            2'd2:    cur_insn = {mem_data, insn};
            default: cur_insn = {8'h00, insn};
        endcase
    end

    assign cur_len = count + 2'd1;
    assign opcode = cur_insn[7:0];
    assign imm8 = cur_insn[15:8];
    assign imm16 = cur_insn[23:8];
    assign done = (state == ST_DONE);

    always_comb begin
        next_state = state;
        next_pc = pc;
        next_addr = addr;
        next_read = 1'b0;
        next_write = 1'b0;
        next_wdata = write_data;
        next_insn = insn;
        next_count = count;
        finish = 1'b0;
        rf.rd_sel = REG_A;
        rf.wr_en = 1'b0;
        rf.wr_pair = 1'b0;
        rf.wr_sel = REG_A;
        rf.wr_pair_sel = pair_sel_t'(cur_insn[5:4]);
        rf.wr_data = {8'h00, imm8};

        if (state == ST_MEM) begin
            // Read data for LD r,(HL) and LD A,(nn) is on the bus now
            if (group == GRP_LD_R_IND_HL || group == GRP_LD_A_IND_NN) begin
                rf.wr_en = 1'b1;
                rf.wr_data = {8'h00, mem_data};
            end
            if (group == GRP_LD_R_IND_HL) begin
                rf.wr_sel = reg_sel_t'(cur_insn[5:3]);
            end
            finish = 1'b1;
        end else begin
            next_pc = pc + 1'b1;
            next_addr = pc + 1'b1;
            next_read = 1'b1;
            next_insn = cur_insn[15:0];
            next_count = cur_len;
            next_state = ST_FETCH;

            if (cur_len == length) begin
                case (group)
                    GRP_LD_R_R: begin
                        rf.rd_sel = reg_sel_t'(cur_insn[2:0]);
                        rf.wr_en = 1'b1;
                        rf.wr_sel = reg_sel_t'(cur_insn[5:3]);
                        rf.wr_data = {8'h00, rf.rd_data};
                        finish = 1'b1;
                    end
                    GRP_LD_R_N: begin
                        rf.wr_en = 1'b1;
                        rf.wr_sel = reg_sel_t'(cur_insn[5:3]);
                        finish = 1'b1;
                    end
                    GRP_LD_DD_NN: begin
                        rf.wr_en = 1'b1;
                        rf.wr_pair = 1'b1;
                        rf.wr_data = imm16;
                        finish = 1'b1;
                    end
                    GRP_LD_R_IND_HL, GRP_LD_A_IND_NN: begin
                        next_addr = (group == GRP_LD_A_IND_NN) ? imm16 : rf.hl;
                        next_state = ST_MEM;
                    end
                    GRP_LD_IND_HL_R, GRP_LD_IND_HL_N, GRP_LD_IND_NN_A: begin
                        rf.rd_sel = (group == GRP_LD_IND_HL_R) ?
                                    reg_sel_t'(cur_insn[2:0]) : REG_A;
                        next_addr = (group == GRP_LD_IND_NN_A) ? imm16 : rf.hl;
                        next_wdata = (group == GRP_LD_IND_HL_N) ? imm8 : rf.rd_data;
                        next_read = 1'b0;
                        next_write = 1'b1;
                        next_state = ST_MEM;
                    end
                    // NOP and anything not decoded end after one byte
                    default: finish = 1'b1;
                endcase
            end
        end

        if (finish) begin
            next_state = ST_DONE;
            next_addr = next_pc;
            next_read = 1'b1;
            next_write = 1'b0;
            next_count = '0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_FETCH;
            pc <= `Z80_RESET_PC;
            addr <= `Z80_RESET_PC;
            read_mem <= 1'b1;
            write_mem <= 1'b0;
            count <= '0;
        end else begin
            state <= next_state;
            pc <= next_pc;
            addr <= next_addr;
            read_mem <= next_read;
            write_mem <= next_write;
            count <= next_count;
        end
    end

    always_ff @(posedge clk) begin
        insn <= next_insn;
        write_data <= next_wdata;
    end

endmodule

//--- logic/z80_core.sv
`include "z80_defines.svh"

module z80_core (
    input  logic clk,
    input  logic reset,
    input  logic [`Z80_DATA_W-1:0] mem_data,
    output logic [`Z80_ADDR_W-1:0] addr,
    output logic read_mem,
    output logic write_mem,
    output logic [`Z80_DATA_W-1:0] write_data,
    output logic done
);
    import z80_pkg::*;

    logic [`Z80_DATA_W-1:0] opcode;
    insn_group_t group;
    logic [1:0] length;

    reg_file_if rf_bus ();

    z80_sequencer sequencer (
        .clk        (clk),
        .reset      (reset),
        .mem_data   (mem_data),
        .addr       (addr),
        .read_mem   (read_mem),
        .write_mem  (write_mem),
        .write_data (write_data),
        .done       (done),
        .opcode     (opcode),
        .group      (group),
        .length     (length),
        .rf         (rf_bus.seq)
    );

    insn_decoder decoder (
        .opcode (opcode),
        .group  (group),
        .length (length)
    );

    register_file registers (
        .clk   (clk),
        .reset (reset),
        .rf    (rf_bus.regs)
    );

endmodule

//--- verification/z80_core_checker.sv
`include "z80_defines.svh"

module z80_core_checker (
    input logic clk,
    input logic reset,
    input logic [`Z80_ADDR_W-1:0] addr,
    input logic read_mem,
    input logic write_mem,
    input logic done
);
    timeunit 1ns;
    timeprecision 1ps;

    no_read_and_write: assert property (@(posedge clk) disable iff (reset)
        !(read_mem && write_mem))
        else $error("read_mem and write_mem are high in the same cycle");

    // Back to back done pulses come only from one byte instructions
    done_single_cycle: assert property (@(posedge clk) disable iff (reset)
        (done && $past(done)) |-> (addr == $past(addr) + 16'd1))
        else $error("done stayed high across an instruction longer than one byte");

    // The next opcode fetch overlaps the done cycle
    done_with_fetch: assert property (@(posedge clk) disable iff (reset) done |-> read_mem)
        else $error("done is high without read_mem");

    start_at_reset_pc: assert property (@(posedge clk)
        $fell(reset) |-> (addr == `Z80_RESET_PC && read_mem))
        else $error("first cycle out of reset does not fetch from the reset address");

endmodule

bind z80_core z80_core_checker protocol_check (
    .clk       (clk),
    .reset     (reset),
    .addr      (addr),
    .read_mem  (read_mem),
    .write_mem (write_mem),
    .done      (done)
);

//--- verification/z80_core_tb.sv
`include "z80_defines.svh"

module z80_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk = 1'b0;
    logic reset;
    logic [`Z80_DATA_W-1:0] mem_data;
    logic [`Z80_ADDR_W-1:0] addr;
    logic read_mem;
    logic write_mem;
    logic [`Z80_DATA_W-1:0] write_data;
    logic done;

    logic [7:0] mem [0:65535];
    logic [7:0] ref_mem [0:65535];
    logic [15:0] got_addr [$];
    logic [7:0] got_data [$];
    logic [15:0] exp_addr [$];
    logic [7:0] exp_data [$];
    int exp_cycles [$];
    int pa = 0;
    int n_insn = 0;
    int errors = 0;
    int wr_idx = 0;
    int dones = 0;
    int cyc = 0;
    int last_done = 1;
    int wait_cycles = 0;

    z80_core uut (
        .clk        (clk),
        .reset      (reset),
        .mem_data   (mem_data),
        .addr       (addr),
        .read_mem   (read_mem),
        .write_mem  (write_mem),
        .write_data (write_data),
        .done       (done)
    );

    always #4 clk = ~clk;

    assign mem_data = mem[addr];

    always @(posedge clk) begin
        if (!reset && write_mem) begin
            got_addr.push_back(addr);
            got_data.push_back(write_data);
            mem[addr] <= write_data;
        end
    end

    task poke(input logic [15:0] a, input logic [7:0] b);
        mem[a] <= b;
        ref_mem[a] = b;
    endtask

    task put(input logic [7:0] b);
        poke(16'(pa), b);
        pa++;
    endtask

    task ld_pair(input logic [1:0] p, input logic [15:0] nn);
        put({2'b00, p, 4'b0001});
        put(nn[7:0]);
        put(nn[15:8]);
    endtask

    // LD A,r followed by LD (nn),A
    task store_via_a(input logic [2:0] r, input logic [15:0] nn);
        put({5'b01111, r});
        put(8'h32);
        put(nn[7:0]);
        put(nn[15:8]);
    endtask

    function automatic logic [2:0] pick_reg();
        logic [2:0] code;
        code = 3'($urandom_range(0, 6));
        return (code == 3'd6) ? 3'd7 : code;
    endfunction

    task build_program();
        logic [2:0] dst;
        for (int i = 0; i < 7; i++) begin
            dst = (i == 6) ? 3'd7 : 3'(i);
            put({2'b00, dst, 3'b110});
            put(8'($urandom));
            store_via_a(dst, 16'h8000 + 16'(i));
        end
        for (int i = 0; i < 16; i++) begin
            dst = pick_reg();
            if ($urandom_range(0, 1) == 0) begin
                put({2'b00, dst, 3'b110});
                put(8'($urandom));
            end else begin
                put({2'b01, dst, pick_reg()});
            end
        end
        store_via_a(3'd4, 16'h8010);
        store_via_a(3'd5, 16'h8011);
        ld_pair(2'd2, 16'h9000);
        for (int i = 0; i < 8; i++) begin
            if (i != 6) put({5'b01110, 3'(i)});
        end
        for (int i = 0; i < 8; i++) begin
            poke(16'ha000 + 16'(i), 8'($urandom));
        end
        put(8'h3a);
        put(8'h07);
        put(8'ha0);
        store_via_a(3'd7, 16'h8100);
        for (int i = 0; i < 7; i++) begin
            dst = (i == 6) ? 3'd7 : 3'(i);
            ld_pair(2'd2, 16'ha000 + 16'(i));
            put({2'b01, dst, 3'b110});
            store_via_a(dst, 16'h8200 + 16'(i));
        end
        // Pair values stay above C000h so (HL) stores miss the program
        for (int p = 0; p < 4; p++) begin
            ld_pair(2'(p), {2'b11, 14'($urandom)});
        end
        put(8'h36);
        put(8'($urandom));
        for (int i = 0; i < 6; i++) begin
            store_via_a(3'(i), 16'h8300 + 16'(i));
        end
        put(8'h76);
        put(8'h00);
        put(8'hc9);
    endtask

    function automatic void expect_write(logic [15:0] a, logic [7:0] d);
        ref_mem[a] = d;
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endfunction

    function automatic int ref_run(int end_pc);
        logic [7:0] regs [0:7];
        logic [7:0] op;
        logic [15:0] nn;
        logic [15:0] hl;
        int pc;
        int count;
        int cycles;
        pc = 0;
        count = 0;
        for (int i = 0; i < 8; i++) regs[i] = 8'h00;
        while (pc < end_pc) begin
            op = ref_mem[pc];
            nn = {ref_mem[pc + 2], ref_mem[pc + 1]};
            hl = {regs[4], regs[5]};
            if (op[7:6] == 2'b01 && op != 8'h76) begin
                cycles = 2;
                if (op[2:0] == 3'd6) regs[op[5:3]] = ref_mem[hl];
                else if (op[5:3] == 3'd6) expect_write(hl, regs[op[2:0]]);
                else begin
                    regs[op[5:3]] = regs[op[2:0]];
                    cycles = 1;
                end
                pc += 1;
            end else if (op[7:6] == 2'b00 && op[2:0] == 3'b110) begin
                cycles = (op[5:3] == 3'd6) ? 3 : 2;
                if (op[5:3] == 3'd6) expect_write(hl, nn[7:0]);
                else regs[op[5:3]] = nn[7:0];
                pc += 2;
            end else if (op == 8'h32 || op == 8'h3a) begin
                if (op == 8'h32) expect_write(nn, regs[7]);
                else regs[7] = ref_mem[nn];
                cycles = 4;
                pc += 3;
            end else if (op[7:6] == 2'b00 && op[3:0] == 4'b0001) begin
                // SP has no 8-bit alias and is left out of the model
                if (op[5:4] != 2'd3) {regs[2 * op[5:4]], regs[2 * op[5:4] + 1]} = nn;
                cycles = 3;
                pc += 3;
            end else begin
                cycles = 1;
                pc += 1;
            end
            exp_cycles.push_back(cycles);
            count++;
        end
        return count;
    endfunction

    always @(negedge clk) begin
        if (!reset) begin
            cyc++;
            while (got_addr.size() > 0) begin
                if (wr_idx >= exp_addr.size()) begin
                    errors++;
                    $display("Unexpected write to %h at %0t", got_addr[0], $time);
                end else begin
                    if (got_addr[0] !== exp_addr[wr_idx]) begin
                        errors++;
                        $display("** Error at %0t: addr expected %h got %h",
                                 $time, exp_addr[wr_idx], got_addr[0]);
                    end
                    if (got_data[0] !== exp_data[wr_idx]) begin
                        errors++;
                        $display("** Error at %0t: write_data expected %h got %h",
                                 $time, exp_data[wr_idx], got_data[0]);
                    end
                end
                wr_idx++;
                void'(got_addr.pop_front());
                void'(got_data.pop_front());
            end
            if (done && dones < n_insn) begin
                if (cyc - last_done != exp_cycles[dones]) begin
                    errors++;
                    $display("** Error at %0t: done interval expected %0d got %0d",
                             $time, exp_cycles[dones], cyc - last_done);
                end
                last_done = cyc;
                dones++;
            end
        end
    end

    initial begin
        reset = 1'b1;
        void'($urandom(94));
        for (int i = 0; i < 65536; i++) begin
            poke(16'(i), 8'h00);
        end
        build_program();
        n_insn = ref_run(pa);
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        while (dones < n_insn && wait_cycles < 5000) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (dones < n_insn) begin
            errors++;
            $display("Timeout: only %0d of %0d instructions completed", dones, n_insn);
        end
        repeat (4) @(negedge clk);
        if (wr_idx != exp_addr.size()) begin
            errors++;
            $display("Saw %0d memory writes but expected %0d", wr_idx, exp_addr.size());
        end
        $display("Instructions: %0d  writes: %0d  errors: %0d", dones, wr_idx, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+logic
logic/z80_pkg.sv
logic/reg_file_if.sv
logic/insn_decoder.sv
logic/register_file.sv
logic/z80_sequencer.sv
logic/z80_core.sv
verification/z80_core_checker.sv
verification/z80_core_tb.sv

//--- run.sh
#!/bin/bash
set -e
set -o pipefail

verilator --binary --assert --timing -Wno-fatal -f flist.f --top-module z80_core_tb \
    -o z80_core_sim
./obj_dir/z80_core_sim | tee sim.log

if grep -q "Finished with errors" sim.log || ! grep -q "Finished with no errors" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
